/* Makefile */
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f build.f --top-module page_walker_tb -o Vpage_walker_tb

run: compile
	./obj_dir/Vpage_walker_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
+incdir+logic
logic/walker_pkg.sv
logic/walk_request_arbiter.sv
logic/pte_address_gen.sv
logic/pte_decoder.sv
logic/walk_control.sv
logic/page_walker.sv
tb/pte_memory.sv
tb/page_walker_tb.sv

/* logic/page_walker.sv */
`timescale 1ns/1ns

module page_walker
(
   input  logic                  clk,
   input  logic                  reset,
   input  walker_pkg::paddr_t    page_table_root,
   input  logic                  l1i_req,
   input  walker_pkg::vaddr_t    l1i_va,
   input  logic                  l1d_req,
   input  walker_pkg::vaddr_t    l1d_va,
   output logic                  l1i_gnt,
   output logic                  l1d_gnt,
   output logic                  mem_req_valid,
   output walker_pkg::paddr_t    mem_req_addr,
   input  logic                  mem_rsp_valid,
   input  walker_pkg::pte_t      mem_rsp_data,
   output logic                  mem_mark_valid,
   output walker_pkg::paddr_t    mem_mark_addr,
   input  logic                  mem_mark_rsp_valid,
   output logic                  l1i_rsp_valid,
   output logic                  l1d_rsp_valid,
   output walker_pkg::walk_rsp_t page_walk_rsp
);

   logic pending_any;
   logic serve_l1i;
   logic start;
   logic load_next;
   logic capture;
   logic finish;
   logic fault;
   logic bad_va;
   logic pte_valid;
   logic pte_leaf;
   logic pte_accessed;
   walker_pkg::walk_level_t level;
   walker_pkg::vaddr_t serve_va;
   walker_pkg::vaddr_t va;
   walker_pkg::paddr_t pte_addr;
   walker_pkg::paddr_t last_addr;
   walker_pkg::pte_t pte_ppn;

   walk_request_arbiter arbiter
   (
      .clk(clk), .reset(reset),
      .l1i_req(l1i_req), .l1d_req(l1d_req),
      .l1i_va(l1i_va), .l1d_va(l1d_va),
      .start(start), .pending_any(pending_any),
      .serve_l1i(serve_l1i), .serve_va(serve_va),
      .l1i_gnt(l1i_gnt), .l1d_gnt(l1d_gnt)
   );

   pte_address_gen address_gen
   (
      .clk(clk), .reset(reset),
      .start(start), .load_next(load_next), .level(level),
      .serve_va(serve_va), .page_table_root(page_table_root),
      .pte_ppn(pte_ppn), .va(va), .bad_va(bad_va), .pte_addr(pte_addr)
   );

   pte_decoder decoder
   (
      .clk(clk), .reset(reset),
      .capture(capture), .finish(finish), .fault(fault), .level(level),
      .mem_rsp_data(mem_rsp_data), .pte_addr(pte_addr), .va(va),
      .pte_valid(pte_valid), .pte_leaf(pte_leaf), .pte_accessed(pte_accessed),
      .pte_ppn(pte_ppn), .last_addr(last_addr), .page_walk_rsp(page_walk_rsp)
   );

   walk_control control
   (
      .clk(clk), .reset(reset),
      .pending_any(pending_any), .serve_l1i(serve_l1i),
      .bad_va(bad_va), .pte_valid(pte_valid), .pte_leaf(pte_leaf),
      .pte_accessed(pte_accessed), .mem_rsp_valid(mem_rsp_valid),
      .mem_mark_rsp_valid(mem_mark_rsp_valid),
      .start(start), .load_next(load_next), .capture(capture),
      .finish(finish), .fault(fault), .level(level),
      .mem_req_valid(mem_req_valid), .mem_mark_valid(mem_mark_valid),
      .l1i_rsp_valid(l1i_rsp_valid), .l1d_rsp_valid(l1d_rsp_valid)
   );

   assign mem_req_addr = pte_addr;
   assign mem_mark_addr = last_addr;   // address of the leaf entry

endmodule

/* logic/pte_address_gen.sv */
`timescale 1ns/1ns
`include "walker_settings.svh"

module pte_address_gen
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    start,
   input  logic                    load_next,
   input  walker_pkg::walk_level_t level,
   input  walker_pkg::vaddr_t      serve_va,
   input  walker_pkg::paddr_t      page_table_root,
   input  walker_pkg::pte_t        pte_ppn,
   output walker_pkg::vaddr_t      va,
   output logic                    bad_va,
   output walker_pkg::paddr_t      pte_addr
);

   walker_pkg::vaddr_t va_q;
   walker_pkg::vaddr_t va_cur;
   walker_pkg::paddr_t base;
   walker_pkg::paddr_t pte_addr_q;
   logic [`WALKER_VPN_BITS-1:0] vpn;
   logic [`WALKER_XLEN-`WALKER_VA_BITS:0] upper;

   assign va_cur = start ? serve_va : va_q;

   // sv39 canonical form, bits 63 down to 38 all equal
   assign upper = va_cur[`WALKER_XLEN-1:`WALKER_VA_BITS-1];
   assign bad_va = !((&upper) || !(|upper));

   always_comb
   begin
      case (level)
         2'd0: vpn = va_cur[(`WALKER_PAGE_BITS + 2*`WALKER_VPN_BITS) +: `WALKER_VPN_BITS];
         2'd1: vpn = va_cur[(`WALKER_PAGE_BITS + `WALKER_VPN_BITS) +: `WALKER_VPN_BITS];
         default: vpn = va_cur[`WALKER_PAGE_BITS +: `WALKER_VPN_BITS];
      endcase
   end

   // root table at level 0, otherwise the table named by the previous entry
   assign base = (level == 2'd0) ? page_table_root : (pte_ppn << `WALKER_PAGE_BITS);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         va_q <= '0;
         pte_addr_q <= '0;
      end
      else
      begin
         if (start)
         begin
            va_q <= serve_va;
         end
         if (load_next)
         begin
            pte_addr_q <= base + {{(`WALKER_XLEN-`WALKER_VPN_BITS-3){1'b0}}, vpn, 3'b000};
         end
      end
   end

   assign va = va_q;
   assign pte_addr = pte_addr_q;

endmodule

/* logic/pte_decoder.sv */
`timescale 1ns/1ns
`include "walker_settings.svh"

module pte_decoder
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    capture,
   input  logic                    finish,
   input  logic                    fault,
   input  walker_pkg::walk_level_t level,
   input  walker_pkg::pte_t        mem_rsp_data,
   input  walker_pkg::paddr_t      pte_addr,
   input  walker_pkg::vaddr_t      va,
   output logic                    pte_valid,
   output logic                    pte_leaf,
   output logic                    pte_accessed,
   output walker_pkg::pte_t        pte_ppn,
   output walker_pkg::paddr_t      last_addr,
   output walker_pkg::walk_rsp_t   page_walk_rsp
);

   localparam int pad_bits = `WALKER_XLEN - `WALKER_PPN_BITS - `WALKER_PAGE_BITS;

   walker_pkg::pte_t pte_q;
   walker_pkg::paddr_t last_addr_q;
   walker_pkg::paddr_t leaf_pa;
   walker_pkg::walk_rsp_t rsp_n;
   walker_pkg::walk_rsp_t rsp_q;
   logic [`WALKER_PPN_BITS-1:0] ppn;

   always_ff @(posedge clk)
   begin
      if (capture)
      begin
         pte_q <= mem_rsp_data;
         last_addr_q <= pte_addr;   // kept for the accessed mark
      end
   end

   assign pte_valid = pte_q[0];
   assign pte_leaf = |pte_q[3:1];   // any of r, w, x
   assign pte_accessed = pte_q[6];
   assign ppn = pte_q[10 +: `WALKER_PPN_BITS];
   assign pte_ppn = {{(`WALKER_XLEN-`WALKER_PPN_BITS){1'b0}}, ppn};
   assign last_addr = last_addr_q;

   // superpages take the low page number bits from the va
   always_comb
   begin
      case (level)
         2'd0: leaf_pa = {{pad_bits{1'b0}}, ppn[`WALKER_PPN_BITS-1:2*`WALKER_VPN_BITS],
                          va[`WALKER_PAGE_BITS+2*`WALKER_VPN_BITS-1:`WALKER_PAGE_BITS],
                          {`WALKER_PAGE_BITS{1'b0}}};
         2'd1: leaf_pa = {{pad_bits{1'b0}}, ppn[`WALKER_PPN_BITS-1:`WALKER_VPN_BITS],
                          va[`WALKER_PAGE_BITS+`WALKER_VPN_BITS-1:`WALKER_PAGE_BITS],
                          {`WALKER_PAGE_BITS{1'b0}}};
         default: leaf_pa = {{pad_bits{1'b0}}, ppn, {`WALKER_PAGE_BITS{1'b0}}};
      endcase
   end

   always_comb
   begin
      rsp_n = '0;
      rsp_n.fault = fault;
      rsp_n.pgsize = level;
      if (!fault)
      begin
         rsp_n.paddr = leaf_pa;
         rsp_n.dirty = pte_q[7];
         rsp_n.readable = pte_q[1];
         rsp_n.writable = pte_q[2];
         rsp_n.executable = pte_q[3];
         rsp_n.user = pte_q[4];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rsp_q <= '0;
      end
      else if (finish)
      begin
         rsp_q <= rsp_n;
      end
   end

   assign page_walk_rsp = rsp_q;

endmodule

/* logic/walk_control.sv */
`timescale 1ns/1ns
`include "walker_settings.svh"

module walk_control
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    pending_any,
   input  logic                    serve_l1i,
   input  logic                    bad_va,
   input  logic                    pte_valid,
   input  logic                    pte_leaf,
   input  logic                    pte_accessed,
   input  logic                    mem_rsp_valid,
   input  logic                    mem_mark_rsp_valid,
   output logic                    start,
   output logic                    load_next,
   output logic                    capture,
   output logic                    finish,
   output logic                    fault,
   output walker_pkg::walk_level_t level,
   output logic                    mem_req_valid,
   output logic                    mem_mark_valid,
   output logic                    l1i_rsp_valid,
   output logic                    l1d_rsp_valid
);

   localparam walker_pkg::walk_level_t last_level =
      walker_pkg::walk_level_t'(`WALKER_LEVELS - 1);

   walker_pkg::walk_state_t state_q;
   walker_pkg::walk_state_t state_n;
   walker_pkg::walk_level_t level_q;
   logic descend;
   logic req_n;
   logic mark_n;
   logic req_q;
   logic mark_q;
   logic l1i_rsp_q;
   logic l1d_rsp_q;

   always_comb
   begin
      state_n = state_q;
      start = 1'b0;
      load_next = 1'b0;
      capture = 1'b0;
      finish = 1'b0;
      fault = 1'b0;
      descend = 1'b0;
      req_n = 1'b0;
      mark_n = 1'b0;
      case (state_q)
         walker_pkg::idle:
         begin
            if (pending_any)
            begin
               start = 1'b1;
               if (bad_va)
               begin
                  state_n = walker_pkg::load;   // no read for a bad va
               end
               else
               begin
                  load_next = 1'b1;
                  req_n = 1'b1;
                  state_n = walker_pkg::wait_pte;
               end
            end
         end
         walker_pkg::wait_pte:
         begin
            capture = mem_rsp_valid;
            if (mem_rsp_valid)
            begin
               state_n = walker_pkg::load;
            end
         end
         walker_pkg::load:
         begin
            if (bad_va)
            begin
               state_n = walker_pkg::done;
            end
            else if (!pte_valid || (!pte_leaf && level_q == last_level))
            begin
               finish = 1'b1;
               fault = 1'b1;
               state_n = walker_pkg::idle;
            end
            else if (pte_leaf)
            begin
               finish = 1'b1;
               mark_n = !pte_accessed;
               state_n = pte_accessed ? walker_pkg::idle : walker_pkg::mark_access;
            end
            else
            begin
               descend = 1'b1;
               load_next = 1'b1;
               req_n = 1'b1;
               state_n = walker_pkg::wait_pte;
            end
         end
         // report of a non-canonical va
         walker_pkg::done:
         begin
            finish = 1'b1;
            fault = 1'b1;
            state_n = walker_pkg::idle;
         end
         walker_pkg::mark_access:
         begin
            if (mem_mark_rsp_valid)
            begin
               state_n = walker_pkg::idle;
            end
         end
         default: state_n = walker_pkg::idle;
      endcase
   end

   // level of the entry being read, or of the leaf on finish
   always_comb
   begin
      if (state_q == walker_pkg::idle)
         level = 2'd0;
      else if (descend)
         level = level_q + 2'd1;
      else
         level = level_q;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_q <= walker_pkg::idle;
         level_q <= 2'd0;
         req_q <= 1'b0;
         mark_q <= 1'b0;
         l1i_rsp_q <= 1'b0;
         l1d_rsp_q <= 1'b0;
      end
      else
      begin
         state_q <= state_n;
         level_q <= level;
         req_q <= req_n;
         mark_q <= mark_n;
         l1i_rsp_q <= finish & serve_l1i;
         l1d_rsp_q <= finish & ~serve_l1i;
      end
   end

   assign mem_req_valid = req_q;
   assign mem_mark_valid = mark_q;   // lines up with the response pulse
   assign l1i_rsp_valid = l1i_rsp_q;
   assign l1d_rsp_valid = l1d_rsp_q;

endmodule

/* logic/walk_request_arbiter.sv */
`timescale 1ns/1ns

module walk_request_arbiter
(
   input  logic               clk,
   input  logic               reset,
   input  logic               l1i_req,
   input  logic               l1d_req,
   input  walker_pkg::vaddr_t l1i_va,
   input  walker_pkg::vaddr_t l1d_va,
   input  logic               start,
   output logic               pending_any,
   output logic               serve_l1i,
   output walker_pkg::vaddr_t serve_va,
   output logic               l1i_gnt,
   output logic               l1d_gnt
);

   logic l1i_pend_q;
   logic l1d_pend_q;
   logic pick_l1i;
   logic serve_l1i_q;
   logic l1i_gnt_q;
   logic l1d_gnt_q;
   walker_pkg::vaddr_t l1i_va_q;
   walker_pkg::vaddr_t l1d_va_q;
   walker_pkg::vaddr_t serve_va_q;
   walker_pkg::vaddr_t pick_va;

   assign pending_any = l1i_pend_q | l1d_pend_q;
   assign pick_l1i = l1i_pend_q;   // instruction side first
   assign pick_va = pick_l1i ? l1i_va_q : l1d_va_q;

   // chosen request shows through during start so level 0 can be formed right away
   assign serve_l1i = start ? pick_l1i : serve_l1i_q;
   assign serve_va = start ? pick_va : serve_va_q;

   assign l1i_gnt = l1i_gnt_q;
   assign l1d_gnt = l1d_gnt_q;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         l1i_pend_q <= 1'b0;
         l1d_pend_q <= 1'b0;
         serve_l1i_q <= 1'b0;
         l1i_gnt_q <= 1'b0;
         l1d_gnt_q <= 1'b0;
      end
      else
      begin
         // a strobe while already pending merges into the same walk
         l1i_pend_q <= (start && pick_l1i) ? 1'b0 : (l1i_pend_q | l1i_req);
         l1d_pend_q <= (start && !pick_l1i) ? 1'b0 : (l1d_pend_q | l1d_req);
         if (start)
         begin
            serve_l1i_q <= pick_l1i;
         end
         l1i_gnt_q <= start & pick_l1i;
         l1d_gnt_q <= start & ~pick_l1i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (l1i_req && !l1i_pend_q)
      begin
         l1i_va_q <= l1i_va;
      end
      if (l1d_req && !l1d_pend_q)
      begin
         l1d_va_q <= l1d_va;
      end
      if (start)
      begin
         serve_va_q <= pick_va;
      end
   end

endmodule

/* logic/walker_pkg.sv */
`include "walker_settings.svh"

package walker_pkg;

   // virtual address as presented by the caches
   typedef logic [`WALKER_XLEN-1:0] vaddr_t;

   typedef logic [`WALKER_XLEN-1:0] paddr_t;

   // raw entry as read from memory
   typedef logic [`WALKER_XLEN-1:0] pte_t;

   // 0 = 1 GiB, 1 = 2 MiB, 2 = 4 KiB
   typedef logic [1:0] walk_level_t;

   typedef enum logic [3:0]
   {
      idle,
      load,
      wait_pte,
      done,
      mark_access
   } walk_state_t;

   // translation result returned to both caches
   typedef struct packed
   {
      paddr_t      paddr;
      logic        fault;
      logic        dirty;
      logic        readable;
      logic        writable;
      logic        executable;
      logic        user;
      walk_level_t pgsize;
   } walk_rsp_t;

endpackage

/* logic/walker_settings.svh */
`ifndef WALKER_SETTINGS_SVH
`define WALKER_SETTINGS_SVH

// width of addresses and page-table entries
`define WALKER_XLEN 64

// significant virtual address bits for sv39
`define WALKER_VA_BITS 39

// index field width at each level
`define WALKER_VPN_BITS 9

// page offset width
`define WALKER_PAGE_BITS 12

// physical page number width inside an entry
`define WALKER_PPN_BITS 44

`define WALKER_LEVELS 3

`endif

/* tb/page_walker_tb.sv */
`timescale 1ns/1ns

module page_walker_tb;

   localparam int n_tests = 9;
   localparam int period = 40;
   localparam walker_pkg::pte_t pte_v = 64'h01;
   localparam walker_pkg::pte_t pte_r = 64'h02;
   localparam walker_pkg::pte_t pte_w = 64'h04;
   localparam walker_pkg::pte_t pte_x = 64'h08;
   localparam walker_pkg::pte_t pte_u = 64'h10;
   localparam walker_pkg::pte_t pte_a = 64'h40;
   localparam walker_pkg::pte_t pte_d = 64'h80;
   localparam walker_pkg::paddr_t root = 64'h0008_0000;

   logic clk;
   logic reset;
   walker_pkg::paddr_t page_table_root;
   logic l1i_req;
   logic l1d_req;
   walker_pkg::vaddr_t l1i_va;
   walker_pkg::vaddr_t l1d_va;
   logic l1i_gnt;
   logic l1d_gnt;
   logic mem_req_valid;
   walker_pkg::paddr_t mem_req_addr;
   logic mem_rsp_valid;
   walker_pkg::pte_t mem_rsp_data;
   logic mem_mark_valid;
   walker_pkg::paddr_t mem_mark_addr;
   logic mem_mark_rsp_valid;
   logic l1i_rsp_valid;
   logic l1d_rsp_valid;
   walker_pkg::walk_rsp_t page_walk_rsp;

   int errors;
   int tests_run;
   int tests_failed;
   int l1i_gnt_count;
   int l1d_gnt_count;
   time l1i_gnt_time;
   time l1d_gnt_time;

   page_walker dut
   (
      .clk(clk), .reset(reset), .page_table_root(page_table_root),
      .l1i_req(l1i_req), .l1i_va(l1i_va), .l1d_req(l1d_req), .l1d_va(l1d_va),
      .l1i_gnt(l1i_gnt), .l1d_gnt(l1d_gnt),
      .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
      .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
      .mem_mark_valid(mem_mark_valid), .mem_mark_addr(mem_mark_addr),
      .mem_mark_rsp_valid(mem_mark_rsp_valid),
      .l1i_rsp_valid(l1i_rsp_valid), .l1d_rsp_valid(l1d_rsp_valid),
      .page_walk_rsp(page_walk_rsp)
   );

   pte_memory mem
   (
      .clk(clk), .reset(reset),
      .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
      .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
      .mem_mark_valid(mem_mark_valid), .mem_mark_addr(mem_mark_addr),
      .mem_mark_rsp_valid(mem_mark_rsp_valid)
   );

   always #(period / 2) clk = ~clk;

   // grant monitor
   always @(posedge clk)
   begin
      if (!reset && l1i_gnt)
      begin
         l1i_gnt_count++;
         l1i_gnt_time = $time;
      end
      if (!reset && l1d_gnt)
      begin
         l1d_gnt_count++;
         l1d_gnt_time = $time;
      end
   end

   initial
   begin
      #(n_tests * 60 * period);
      $display("watchdog expired, the tests did not finish in time");
      $display("SIMULATION FAILED");
      $finish;
   end

   task automatic check_rsp(input string what, input walker_pkg::walk_rsp_t got,
                            input walker_pkg::walk_rsp_t exp);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input string what, input walker_pkg::paddr_t got,
                             input walker_pkg::paddr_t exp);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp)
      begin
         $display("FAIL at %0t: %s got %0d expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   function automatic walker_pkg::paddr_t vpn_of(input walker_pkg::vaddr_t va, input int lvl);
      return (va >> (12 + 9 * (2 - lvl))) & 64'h1ff;
   endfunction

   function automatic walker_pkg::pte_t pointer_pte(input walker_pkg::paddr_t ppn);
      return (ppn << 10) | pte_v;
   endfunction

   // sv39 superpage rule, low ppn bits come from the va
   function automatic walker_pkg::paddr_t expect_pa(input walker_pkg::pte_t pte,
                                                    input walker_pkg::vaddr_t va, input int lvl);
      walker_pkg::paddr_t ppn;
      walker_pkg::paddr_t low;
      int keep;
      ppn = (pte >> 10) & 64'h0000_0fff_ffff_ffff;
      keep = 9 * (2 - lvl);
      low = (va >> 12) & ((64'h1 << keep) - 1);
      return (((ppn >> keep) << keep) | low) << 12;
   endfunction

   function automatic walker_pkg::walk_rsp_t leaf_rsp(input walker_pkg::pte_t pte,
                                                      input walker_pkg::vaddr_t va, input int lvl);
      walker_pkg::walk_rsp_t r;
      r = '0;
      r.paddr = expect_pa(pte, va, lvl);
      r.dirty = pte[7];
      r.readable = pte[1];
      r.writable = pte[2];
      r.executable = pte[3];
      r.user = pte[4];
      r.pgsize = walker_pkg::walk_level_t'(lvl);
      return r;
   endfunction

   function automatic walker_pkg::walk_rsp_t fault_rsp(input int lvl);
      walker_pkg::walk_rsp_t r;
      r = '0;
      r.fault = 1'b1;
      r.pgsize = walker_pkg::walk_level_t'(lvl);
      return r;
   endfunction

   // pointer entries down to leaf_level, then the given entry
   task automatic build_chain(input walker_pkg::vaddr_t va, input int leaf_level,
                              input walker_pkg::pte_t leaf, input walker_pkg::paddr_t tbl_ppn,
                              output walker_pkg::paddr_t leaf_addr);
      walker_pkg::paddr_t base;
      walker_pkg::paddr_t addr;
      int lvl;
      base = root;
      addr = '0;
      for (lvl = 0; lvl <= leaf_level; lvl++)
      begin
         addr = base + 8 * vpn_of(va, lvl);
         if (lvl == leaf_level)
            mem.write_entry(addr, leaf);
         else
         begin
            mem.write_entry(addr, pointer_pte(tbl_ppn + lvl));
            base = (tbl_ppn + lvl) << 12;
         end
      end
      leaf_addr = addr;
   endtask

   task automatic issue(input logic to_l1i, input walker_pkg::vaddr_t va);
      @(posedge clk);
      #2;
      if (to_l1i)
      begin
         l1i_req = 1'b1;
         l1i_va = va;
      end
      else
      begin
         l1d_req = 1'b1;
         l1d_va = va;
      end
      @(posedge clk);
      #2;
      l1i_req = 1'b0;
      l1d_req = 1'b0;
   endtask

   task automatic wait_rsp(input logic from_l1i, output walker_pkg::walk_rsp_t rsp,
                           output time t);
      int n;
      logic got;
      got = 1'b0;
      rsp = '0;
      t = 0;
      for (n = 0; n < 100 && !got; n++)
      begin
         @(negedge clk);
         if (from_l1i ? l1i_rsp_valid : l1d_rsp_valid)
         begin
            got = 1'b1;
            rsp = page_walk_rsp;
            t = $time;
         end
      end
      if (!got)
      begin
         $display("no response from the walker by %0t", $time);
         errors++;
      end
   endtask

   task automatic begin_test();
      mem.clear_table();
      mem.clear_counts();
      l1i_gnt_count = 0;
      l1d_gnt_count = 0;
      l1i_gnt_time = 0;
      l1d_gnt_time = 0;
   endtask

   task automatic end_test(input string name, input int errors_before);
      repeat (6) @(posedge clk);   // let any mark handshake drain
      tests_run++;
      if (errors == errors_before)
         $display("test %s passed", name);
      else
      begin
         tests_failed++;
         $display("test %s failed", name);
      end
   endtask

   task automatic test_4k_walk();
      walker_pkg::vaddr_t va;
      walker_pkg::pte_t leaf;
      walker_pkg::paddr_t leaf_addr;
      walker_pkg::walk_rsp_t rsp;
      time t;
      int e0;
      e0 = errors;
      begin_test();
      va = (64'd1 << 30) | (64'd2 << 21) | (64'd3 << 12) | 64'h123;
      leaf = (64'h12345 << 10) | pte_v | pte_r | pte_w | pte_u | pte_a | pte_d;
      build_chain(va, 2, leaf, 64'h100, leaf_addr);
      issue(1'b0, va);
      wait_rsp(1'b0, rsp, t);
      check_rsp("4k response", rsp, leaf_rsp(leaf, va, 2));
      check_addr("4k paddr", rsp.paddr, 64'h12345 << 12);
      check_count("4k reads", mem.read_count, 3);
      check_count("grant before response", int'(l1d_gnt_time != 0 && l1d_gnt_time < t), 1);
      end_test("4k_walk", e0);
   endtask

   task automatic test_superpage(input int lvl, input string name);
      walker_pkg::vaddr_t va;
      walker_pkg::pte_t leaf;
      walker_pkg::paddr_t leaf_addr;
      walker_pkg::walk_rsp_t rsp;
      time t;
      int e0;
      e0 = errors;
      begin_test();
      va = (64'd4 << 30) | (64'd5 << 21) | (64'd7 << 12) | 64'h0ab;
      leaf = (64'h0abc_dfff << 10) | pte_v | pte_r | pte_x | pte_a;
      build_chain(va, lvl, leaf, 64'h200, leaf_addr);
      issue(1'b1, va);
      wait_rsp(1'b1, rsp, t);
      check_rsp({name, " response"}, rsp, leaf_rsp(leaf, va, lvl));
      check_count({name, " reads"}, mem.read_count, lvl + 1);
      end_test(name, e0);
   endtask

   task automatic test_fault_bad_va();
      walker_pkg::walk_rsp_t rsp;
      time t;
      int e0;
      e0 = errors;
      begin_test();
      issue(1'b0, 64'h0000_0040_0000_1000);
      wait_rsp(1'b0, rsp, t);
      check_rsp("bad va response", rsp, fault_rsp(0));
      check_count("bad va reads", mem.read_count, 0);
      end_test("fault_bad_va", e0);
   endtask

   task automatic test_fault_chain(input int lvl, input walker_pkg::pte_t bad_entry,
                                   input string name);
      walker_pkg::vaddr_t va;
      walker_pkg::paddr_t leaf_addr;
      walker_pkg::walk_rsp_t rsp;
      time t;
      int e0;
      e0 = errors;
      begin_test();
      va = 64'hffff_ffc0_1234_5000;   // upper half, still canonical
      build_chain(va, lvl, bad_entry, 64'h300, leaf_addr);
      issue(1'b0, va);
      wait_rsp(1'b0, rsp, t);
      check_rsp({name, " response"}, rsp, fault_rsp(lvl));
      check_count({name, " reads"}, mem.read_count, lvl + 1);
      end_test(name, e0);
   endtask

   task automatic test_mark_clear();
      walker_pkg::vaddr_t va1;
      walker_pkg::vaddr_t va2;
      walker_pkg::pte_t leaf1;
      walker_pkg::pte_t leaf2;
      walker_pkg::paddr_t addr1;
      walker_pkg::paddr_t addr2;
      walker_pkg::walk_rsp_t rsp;
      time t;
      int e0;
      e0 = errors;
      begin_test();
      va1 = (64'd6 << 30) | (64'd1 << 21) | (64'd9 << 12);
      va2 = (64'd7 << 30) | (64'd2 << 21) | (64'd8 << 12);
      leaf1 = (64'h4444 << 10) | pte_v | pte_r | pte_w;
      leaf2 = (64'h5555 << 10) | pte_v | pte_r | pte_a;
      build_chain(va1, 2, leaf1, 64'h400, addr1);
      build_chain(va2, 2, leaf2, 64'h500, addr2);
      issue(1'b0, va1);
      issue(1'b1, va2);   // arrives while the first walk is busy
      wait_rsp(1'b0, rsp, t);
      check_rsp("mark walk response", rsp, leaf_rsp(leaf1, va1, 2));
      wait_rsp(1'b1, rsp, t);
      check_rsp("follow-up response", rsp, leaf_rsp(leaf2, va2, 2));
      repeat (6) @(posedge clk);
      check_count("mark requests", mem.mark_count, 1);
      check_addr("mark address", mem.last_mark_addr, addr1);
      check_count("grant after mark ack",
                  int'(mem.first_ack_time != 0 && l1i_gnt_time > mem.first_ack_time), 1);
      end_test("mark_clear", e0);
   endtask

   task automatic test_mark_set();
      walker_pkg::vaddr_t va;
      walker_pkg::pte_t leaf;
      walker_pkg::paddr_t leaf_addr;
      walker_pkg::walk_rsp_t rsp;
      time t;
      int e0;
      e0 = errors;
      begin_test();
      va = (64'd3 << 30) | (64'd3 << 21) | (64'd3 << 12);
      leaf = (64'h7777 << 10) | pte_v | pte_x | pte_a;
      build_chain(va, 2, leaf, 64'h600, leaf_addr);
      issue(1'b0, va);
      wait_rsp(1'b0, rsp, t);
      check_rsp("accessed leaf response", rsp, leaf_rsp(leaf, va, 2));
      repeat (6) @(posedge clk);
      check_count("mark requests", mem.mark_count, 0);
      end_test("mark_set", e0);
   endtask

   task automatic test_arbitration();
      walker_pkg::vaddr_t va_i;
      walker_pkg::vaddr_t va_d;
      walker_pkg::pte_t leaf_i;
      walker_pkg::pte_t leaf_d;
      walker_pkg::paddr_t addr;
      walker_pkg::walk_rsp_t rsp_i;
      walker_pkg::walk_rsp_t rsp_d;
      time t_i;
      time t_d;
      int e0;
      e0 = errors;
      begin_test();
      va_i = (64'd8 << 30) | (64'd4 << 21) | (64'd2 << 12);
      va_d = (64'd9 << 30) | (64'd6 << 21) | (64'd5 << 12);
      leaf_i = (64'h1_2000 << 10) | pte_v | pte_x | pte_a;
      leaf_d = (64'h3_4e00 << 10) | pte_v | pte_r | pte_w | pte_a | pte_d;
      build_chain(va_i, 2, leaf_i, 64'h700, addr);
      build_chain(va_d, 1, leaf_d, 64'h800, addr);
      @(posedge clk);
      #2;
      l1i_req = 1'b1;
      l1i_va = va_i;
      l1d_req = 1'b1;
      l1d_va = va_d;
      @(posedge clk);
      #2;
      l1i_req = 1'b0;
      l1d_req = 1'b0;
      wait_rsp(1'b1, rsp_i, t_i);
      wait_rsp(1'b0, rsp_d, t_d);
      check_rsp("instruction response", rsp_i, leaf_rsp(leaf_i, va_i, 2));
      check_rsp("data response", rsp_d, leaf_rsp(leaf_d, va_d, 1));
      check_count("instruction grants", l1i_gnt_count, 1);
      check_count("data grants", l1d_gnt_count, 1);
      check_count("instruction granted first", int'(l1i_gnt_time < l1d_gnt_time), 1);
      check_count("data granted after instruction response", int'(l1d_gnt_time > t_i), 1);
      end_test("arbitration", e0);
   endtask

   initial
   begin
      clk = 1'b0;
      reset = 1'b1;
      page_table_root = root;
      l1i_req = 1'b0;
      l1d_req = 1'b0;
      l1i_va = '0;
      l1d_va = '0;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (2) @(posedge clk);
      #2;
      reset = 1'b0;

      test_4k_walk();
      test_superpage(1, "superpage_2m");
      test_superpage(0, "superpage_1g");
      test_fault_bad_va();
      test_fault_chain(1, 64'h0, "fault_invalid");
      test_fault_chain(2, pointer_pte(64'h900), "fault_nonleaf");
      test_mark_clear();
      test_mark_set();
      test_arbitration();

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* tb/pte_memory.sv */
`timescale 1ns/1ns

module pte_memory
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  mem_req_valid,
   input  walker_pkg::paddr_t    mem_req_addr,
   output logic                  mem_rsp_valid,
   output walker_pkg::pte_t      mem_rsp_data,
   input  logic                  mem_mark_valid,
   input  walker_pkg::paddr_t    mem_mark_addr,
   output logic                  mem_mark_rsp_valid
);

   walker_pkg::pte_t table_q [walker_pkg::paddr_t];   // sparse page tables
   int read_count;
   int mark_count;
   int ack_count;
   walker_pkg::paddr_t last_mark_addr;
   time first_ack_time;

   task automatic write_entry(input walker_pkg::paddr_t addr, input walker_pkg::pte_t data);
      table_q[addr] = data;
   endtask

   task automatic clear_table();
      table_q.delete();
   endtask

   task automatic clear_counts();
      read_count = 0;
      mark_count = 0;
      ack_count = 0;
      last_mark_addr = '0;
      first_ack_time = 0;
   endtask

   initial
   begin
      int delay;
      walker_pkg::paddr_t addr;
      void'($urandom(32'h2316));
      mem_rsp_valid = 1'b0;
      mem_rsp_data = '0;
      mem_mark_rsp_valid = 1'b0;
      clear_counts();
      // one read in flight, answered 1 to 4 cycles later
      forever
      begin
         @(posedge clk);
         if (!reset && mem_req_valid)
         begin
            addr = mem_req_addr;
            read_count++;
            delay = 1 + int'($urandom % 4);
            repeat (delay - 1) @(posedge clk);
            #2;
            mem_rsp_valid = 1'b1;
            mem_rsp_data = table_q.exists(addr) ? table_q[addr] : '0;   // unmapped reads as invalid
            @(posedge clk);
            #2;
            mem_rsp_valid = 1'b0;
         end
      end
   end

   always
   begin
      @(posedge clk);
      if (!reset && mem_mark_valid)
      begin
         mark_count++;
         last_mark_addr = mem_mark_addr;
         @(posedge clk);
         #2;
         mem_mark_rsp_valid = 1'b1;
         @(posedge clk);
         if (ack_count == 0)
            first_ack_time = $time;
         ack_count++;
         #2;
         mem_mark_rsp_valid = 1'b0;
      end
   end

endmodule
